// File: hw/lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

    // Every data word, address and instruction in the LC-3b is 16 bits wide.
    typedef logic [15:0] lc3b_word;

    // The opcode sits in the top nibble of the instruction register.
    localparam int opcode_msb = 15;
    localparam int opcode_lsb = 12;

    // Encodings follow the LC-3b instruction set.
    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

endpackage : lc3b_isa_pkg

`default_nettype wire

// File: hw/lc3b_mem_pkg.sv
`default_nettype none

package lc3b_mem_pkg;

    // The on-chip data memory holds 256 aligned 16-bit words.
    localparam int sram_depth = 256;

    // Word index into the SRAM, taken from byte address bits 8 down to 1.
    typedef logic [7:0] sram_addr;
    localparam int sram_addr_msb = 8;
    localparam int sram_addr_lsb = 1;

    // Source of the data memory address.
    typedef enum logic {
        addr_sel_alu          = 1'b0,
        addr_sel_internal_mdr = 1'b1
    } lc3b_data_memory_addr_mux_sel;

    // Number of wait states the SRAM inserts before it acknowledges.
    typedef logic [3:0] wait_count;

    // Timing register index and data.
    typedef logic [0:0] cfg_addr;
    typedef logic [7:0] cfg_data;

    localparam cfg_addr cfg_idx_wait  = 1'b0;
    localparam cfg_addr cfg_idx_retry = 1'b1;

endpackage : lc3b_mem_pkg

`default_nettype wire

// File: hw/mem_access_controller.sv
`timescale 1ns/10ps
`default_nettype none

module mem_access_controller (
    input  wire  logic                                       clk,
    input  wire  logic                                       arst_n,
    input  wire  logic                                       stall,
    input  wire  lc3b_isa_pkg::lc3b_word                     ir,
    input  wire  logic                                       mem_access,
    input  wire  logic                                       mem_write,
    input  wire  lc3b_mem_pkg::lc3b_data_memory_addr_mux_sel addr_sel_in,
    input  wire  logic                                       ack,
    input  wire  logic                                       rty,
    output lc3b_mem_pkg::lc3b_data_memory_addr_mux_sel       addr_sel,
    output logic                                             mem_we,
    output logic                                             mdr_load,
    output logic                                             request_stall
);

    import lc3b_isa_pkg::*;
    import lc3b_mem_pkg::*;

    typedef enum logic {
        s_access_1,
        s_access_2
    } state_t;

    state_t     state;
    state_t     next_state;
    lc3b_opcode opcode;
    logic       indirect;
    logic       clean_ack;
    logic       state_stall;
    logic       memory_stall;

    assign opcode    = lc3b_opcode'(ir[opcode_msb:opcode_lsb]);
    assign indirect  = (opcode == op_ldi) || (opcode == op_sti);
    assign clean_ack = mem_access & ack & ~rty;

    // The access itself stalls the pipe until the SRAM gives an ack without a retry.
    assign memory_stall  = mem_access & (~ack | rty);
    assign request_stall = state_stall | memory_stall;

    always_comb begin
        addr_sel    = addr_sel_in;
        mem_we      = mem_access & mem_write;
        mdr_load    = 1'b0;
        state_stall = 1'b0;
        next_state  = state;

        case (state)
            s_access_1: begin
                // The first half of LDI and STI always reads the pointer word.
                if (mem_access && indirect) begin
                    mem_we      = 1'b0;
                    mdr_load    = clean_ack;
                    state_stall = 1'b1;
                    if (clean_ack) begin
                        next_state = s_access_2;
                    end
                end
            end

            s_access_2: begin
                addr_sel = addr_sel_internal_mdr;
                if (clean_ack) begin
                    next_state = s_access_1;
                end
            end

            default: begin
                next_state = s_access_1;
            end
        endcase
    end

    // The stall input is the external hold only. The stall this block raises by
    // state must not freeze its own sequencing, or the pointer read never ends.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= s_access_1;
        end else if (!stall) begin
            state <= next_state;
        end
    end

    // The pointer phase is only reached from an indirect instruction, and that
    // instruction is still presented when the second access begins.
    assert property (@(posedge clk) disable iff (!arst_n)
        $rose(state == s_access_2) |-> $past(indirect && mem_access) && indirect);

endmodule : mem_access_controller

`default_nettype wire

// File: hw/mem_stage_datapath.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage_datapath (
    input  wire logic                                       clk,
    input  wire logic                                       arst_n,
    input  wire logic                                       stall,
    input  wire lc3b_mem_pkg::lc3b_data_memory_addr_mux_sel addr_sel,
    input  wire logic                                       mdr_load,
    input  wire lc3b_isa_pkg::lc3b_word                     alu_addr,
    input  wire lc3b_isa_pkg::lc3b_word                     rdata,
    output lc3b_mem_pkg::sram_addr                          mem_addr
);

    import lc3b_isa_pkg::*;
    import lc3b_mem_pkg::*;

    lc3b_word internal_mdr;
    lc3b_word byte_addr;

    // The internal MDR keeps the pointer fetched by the first half of LDI and STI.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            internal_mdr <= '0;
        end else if (mdr_load && !stall) begin
            internal_mdr <= rdata;
        end
    end

    always_comb begin
        case (addr_sel)
            addr_sel_alu:          byte_addr = alu_addr;
            addr_sel_internal_mdr: byte_addr = internal_mdr;
            default:               byte_addr = alu_addr;
        endcase
    end

    // Accesses are word aligned, so byte address bit 0 is dropped.
    assign mem_addr = byte_addr[sram_addr_msb:sram_addr_lsb];

endmodule : mem_stage_datapath

`default_nettype wire

// File: hw/data_sram.sv
`timescale 1ns/10ps
`default_nettype none

module data_sram (
    input  wire logic                      clk,
    input  wire logic                      arst_n,
    input  wire logic                      req,
    input  wire logic                      we,
    input  wire lc3b_mem_pkg::sram_addr    addr,
    input  wire lc3b_isa_pkg::lc3b_word    wdata,
    input  wire lc3b_mem_pkg::wait_count   wait_states,
    input  wire logic                      retry_en,
    output lc3b_isa_pkg::lc3b_word         rdata,
    output logic                           ack,
    output logic                           rty
);

    import lc3b_isa_pkg::*;
    import lc3b_mem_pkg::*;

    lc3b_word  mem [sram_depth];
    wait_count count;
    logic      retry_done;
    logic      commit;

    // Reads are combinational from the word array.
    assign rdata = mem[addr];

    // The access is acknowledged once the counter reaches the wait-state setting.
    assign ack = req && (count == wait_states);

    // With retry injection on, the first ack of an access is refused once.
    assign rty = ack && retry_en && !retry_done;

    assign commit = ack && !rty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count      <= '0;
            retry_done <= 1'b0;
        end else if (!req) begin
            count      <= '0;
            retry_done <= 1'b0;
        end else if (rty) begin
            // A refused access starts its wait over again.
            count      <= '0;
            retry_done <= 1'b1;
        end else if (commit) begin
            count      <= '0;
            retry_done <= 1'b0;
        end else begin
            count <= count + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (commit && we) begin
            mem[addr] <= wdata;
        end
    end

    // During an access the wait counter never runs past the wait-state setting.
    assert property (@(posedge clk) disable iff (!arst_n)
        req |-> count <= wait_states);

endmodule : data_sram

`default_nettype wire

// File: hw/mem_timing_regs.sv
`timescale 1ns/10ps
`default_nettype none

module mem_timing_regs (
    input  wire logic                    clk,
    input  wire logic                    arst_n,
    input  wire logic                    cfg_we,
    input  wire lc3b_mem_pkg::cfg_addr   cfg_addr,
    input  wire lc3b_mem_pkg::cfg_data   cfg_wdata,
    output lc3b_mem_pkg::cfg_data        cfg_rdata,
    output lc3b_mem_pkg::wait_count      wait_states,
    output logic                         retry_en
);

    import lc3b_mem_pkg::*;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wait_states <= '0;
            retry_en    <= 1'b0;
        end else if (cfg_we) begin
            if (cfg_addr == cfg_idx_wait) begin
                wait_states <= cfg_wdata[$bits(wait_count)-1:0];
            end else begin
                retry_en <= cfg_wdata[0];
            end
        end
    end

    // Readback is zero extended to the full configuration width.
    always_comb begin
        if (cfg_addr == cfg_idx_retry) begin
            cfg_rdata = cfg_data'(retry_en);
        end else begin
            cfg_rdata = cfg_data'(wait_states);
        end
    end

endmodule : mem_timing_regs

`default_nettype wire

// File: hw/lc3b_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module lc3b_mem_stage (
    input  wire logic                                       clk,
    input  wire logic                                       arst_n,
    input  wire logic                                       hold,
    input  wire lc3b_isa_pkg::lc3b_word                     ir,
    input  wire logic                                       mem_access,
    input  wire logic                                       mem_write,
    input  wire lc3b_mem_pkg::lc3b_data_memory_addr_mux_sel addr_sel,
    input  wire lc3b_isa_pkg::lc3b_word                     alu_addr,
    input  wire lc3b_isa_pkg::lc3b_word                     store_data,
    input  wire logic                                       cfg_we,
    input  wire lc3b_mem_pkg::cfg_addr                      cfg_addr,
    input  wire lc3b_mem_pkg::cfg_data                      cfg_wdata,
    output lc3b_isa_pkg::lc3b_word                          load_data,
    output logic                                            request_stall,
    output lc3b_mem_pkg::cfg_data                           cfg_rdata
);

    import lc3b_isa_pkg::*;
    import lc3b_mem_pkg::*;

    lc3b_data_memory_addr_mux_sel ctrl_addr_sel;
    logic                         mem_we;
    logic                         mdr_load;
    sram_addr                     mem_addr;
    lc3b_word                     rdata;
    logic                         ack;
    logic                         rty;
    wait_count                    wait_states;
    logic                         retry_en;

    assign load_data = rdata;

    mem_access_controller ctrl0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .stall         (hold),
        .ir            (ir),
        .mem_access    (mem_access),
        .mem_write     (mem_write),
        .addr_sel_in   (addr_sel),
        .ack           (ack),
        .rty           (rty),
        .addr_sel      (ctrl_addr_sel),
        .mem_we        (mem_we),
        .mdr_load      (mdr_load),
        .request_stall (request_stall)
    );

    mem_stage_datapath dp0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .stall    (hold),
        .addr_sel (ctrl_addr_sel),
        .mdr_load (mdr_load),
        .alu_addr (alu_addr),
        .rdata    (rdata),
        .mem_addr (mem_addr)
    );

    data_sram sram0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .req         (mem_access),
        .we          (mem_we),
        .addr        (mem_addr),
        .wdata       (store_data),
        .wait_states (wait_states),
        .retry_en    (retry_en),
        .rdata       (rdata),
        .ack         (ack),
        .rty         (rty)
    );

    mem_timing_regs timing0 (
        .clk         (clk),
        .arst_n      (arst_n),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_rdata   (cfg_rdata),
        .wait_states (wait_states),
        .retry_en    (retry_en)
    );

endmodule : lc3b_mem_stage

`default_nettype wire

// File: verification/mem_stage_model.svh
`ifndef MEM_STAGE_MODEL_SVH
`define MEM_STAGE_MODEL_SVH

// Shadow copy of the data SRAM, one entry per aligned word.
lc3b_word shadow_mem [sram_depth];

// Byte address bits 8 down to 1 pick the word. Bit 0 is ignored.
function automatic sram_addr word_of(input lc3b_word byte_addr);
    return byte_addr[8:1];
endfunction

function automatic logic is_indirect(input lc3b_opcode op);
    return (op == op_ldi) || (op == op_sti);
endfunction

function automatic logic is_store(input lc3b_opcode op);
    return (op == op_str) || (op == op_sti);
endfunction

// Word the instruction really reads or writes. LDI and STI go through the pointer word.
function automatic sram_addr target_of(input lc3b_opcode op, input lc3b_word byte_addr);
    if (is_indirect(op)) begin
        return word_of(shadow_mem[word_of(byte_addr)]);
    end else begin
        return word_of(byte_addr);
    end
endfunction

// One access lasts W+1 cycles, and twice that when its first ack is refused.
function automatic int access_cycles(input int w, input logic retry);
    return retry ? 2 * (w + 1) : w + 1;
endfunction

// Indirect instructions make two full accesses.
function automatic int instr_cycles(input lc3b_opcode op, input int w, input logic retry);
    return is_indirect(op) ? 2 * access_cycles(w, retry) : access_cycles(w, retry);
endfunction

`endif

// File: verification/tb_lc3b_mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_lc3b_mem_stage;

    import lc3b_isa_pkg::*;
    import lc3b_mem_pkg::*;

    localparam int clk_period = 100;
    localparam int wait_limit = 2000;
    localparam int seed       = 32'h6595;

    logic                         clk;
    logic                         arst_n;
    logic                         hold;
    lc3b_word                     ir;
    logic                         mem_access;
    logic                         mem_write;
    lc3b_data_memory_addr_mux_sel addr_sel;
    lc3b_word                     alu_addr;
    lc3b_word                     store_data;
    logic                         cfg_we;
    cfg_addr                      cfg_index;
    cfg_data                      cfg_wdata;
    lc3b_word                     load_data;
    logic                         request_stall;
    cfg_data                      cfg_rdata;

    int         checks;
    int         errors;
    int         tests;
    int         test_errors;
    string      test_name;
    int         cur_w;
    logic       cur_retry;
    lc3b_opcode mem_ops [4];

    `include "mem_stage_model.svh"

    lc3b_mem_stage dut0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .hold          (hold),
        .ir            (ir),
        .mem_access    (mem_access),
        .mem_write     (mem_write),
        .addr_sel      (addr_sel),
        .alu_addr      (alu_addr),
        .store_data    (store_data),
        .cfg_we        (cfg_we),
        .cfg_addr      (cfg_index),
        .cfg_wdata     (cfg_wdata),
        .load_data     (load_data),
        .request_stall (request_stall),
        .cfg_rdata     (cfg_rdata)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(clk_period / 2) clk = ~clk;
        end
    end

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        $display("Test %s finished with %0d mismatches", test_name, test_errors);
    endtask

    task automatic check_word(input string what, input lc3b_word exp, input lc3b_word act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_cfg(input string what, input cfg_data exp, input cfg_data act);
        checks++;
        if (act !== exp) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    // A range check, exact when lo equals hi.
    task automatic check_count(input string what, input int lo, input int hi, input int act);
        checks++;
        if (act < lo || act > hi) begin
            errors++;
            test_errors++;
            $display("[ERROR] %s %s: expected %0d to %0d, actual %0d",
                     test_name, what, lo, hi, act);
        end
    endtask

    function automatic lc3b_word random_addr();
        return lc3b_word'($urandom);
    endfunction

    task automatic write_cfg(input cfg_addr idx, input cfg_data data);
        @(negedge clk);
        mem_access = 1'b0;
        hold       = 1'b0;
        cfg_we     = 1'b1;
        cfg_index  = idx;
        cfg_wdata  = data;
        @(negedge clk);
        cfg_we = 1'b0;
    endtask

    task automatic expect_cfg(input cfg_addr idx, input cfg_data exp, input string what);
        @(negedge clk);
        cfg_index = idx;
        #(clk_period / 10);
        check_cfg(what, exp, cfg_rdata);
    endtask

    task automatic set_timing(input int w, input logic retry);
        write_cfg(cfg_idx_wait, cfg_data'(w));
        write_cfg(cfg_idx_retry, cfg_data'(retry));
        cur_w     = w;
        cur_retry = retry;
    endtask

    // Presents one instruction and keeps it steady until the global stall drops.
    task automatic run_instr(input lc3b_opcode op, input lc3b_word addr, input lc3b_word data,
                             input int hold_pct, output lc3b_word loaded, output int cycles,
                             output int holds);
        logic        stalled;
        logic [11:0] operand_bits;
        cycles       = 0;
        holds        = 0;
        loaded       = '0;
        stalled      = 1'b1;
        operand_bits = $urandom_range(12'hfff);
        @(negedge clk);
        ir         = {op, operand_bits};
        mem_access = 1'b1;
        mem_write  = is_store(op);
        addr_sel   = addr_sel_alu;
        alu_addr   = addr;
        store_data = data;
        hold       = ($urandom_range(99) < hold_pct);
        while (stalled) begin
            #(clk_period / 10);
            stalled = hold | request_stall;
            loaded  = load_data;
            if (hold) begin
                holds++;
            end
            @(posedge clk);
            cycles++;
            if (!stalled) begin
                stalled = 1'b0;
            end else if (cycles >= wait_limit) begin
                $display("Timeout in %s: %s still stalled after %0d cycles",
                         test_name, op.name(), cycles);
                $display("ERRORS FOUND");
                $finish;
            end else begin
                @(negedge clk);
                hold = ($urandom_range(99) < hold_pct);
            end
        end
    endtask

    // Runs one instruction, updates the shadow memory and checks data and latency.
    task automatic exec(input lc3b_opcode op, input lc3b_word addr, input lc3b_word data,
                        input int hold_pct);
        sram_addr target;
        lc3b_word expected;
        lc3b_word loaded;
        int       cycles;
        int       holds;
        int       min_cycles;
        target     = target_of(op, addr);
        expected   = shadow_mem[target];
        min_cycles = instr_cycles(op, cur_w, cur_retry);
        run_instr(op, addr, data, hold_pct, loaded, cycles, holds);
        if (is_store(op)) begin
            shadow_mem[target] = data;
        end else begin
            check_word($sformatf("%s data", op.name()), expected, loaded);
        end
        // A hold that lands on a completing ack repeats that whole access.
        check_count($sformatf("%s cycles", op.name()), min_cycles,
                    min_cycles + holds * access_cycles(cur_w, cur_retry), cycles);
    endtask

    initial begin
        cfg_data  value;
        lc3b_word addr;
        lc3b_word ptr;
        lc3b_word data;
        sram_addr target;
        void'($urandom(seed));
        checks     = 0;
        errors     = 0;
        tests      = 0;
        cur_w      = 0;
        cur_retry  = 1'b0;
        mem_ops    = '{op_ldr, op_str, op_ldi, op_sti};
        hold       = 1'b0;
        ir         = '0;
        mem_access = 1'b0;
        mem_write  = 1'b0;
        addr_sel   = addr_sel_alu;
        alu_addr   = '0;
        store_data = '0;
        cfg_we     = 1'b0;
        cfg_index  = cfg_idx_wait;
        cfg_wdata  = '0;
        arst_n     = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        start_test("config_regs");
        expect_cfg(cfg_idx_wait, 8'h00, "wait after reset");
        expect_cfg(cfg_idx_retry, 8'h00, "retry after reset");
        repeat (8) begin
            value = $urandom_range(255);
            write_cfg(cfg_idx_wait, value);
            expect_cfg(cfg_idx_wait, {4'h0, value[3:0]}, "wait readback");
            value = $urandom_range(255);
            write_cfg(cfg_idx_retry, value);
            expect_cfg(cfg_idx_retry, {7'h0, value[0]}, "retry readback");
        end
        set_timing(0, 1'b0);
        end_test();

        // Every word is written first so that later loads never see an unknown value.
        start_test("str_ldr_no_wait");
        for (int i = 0; i < sram_depth; i++) begin
            exec(op_str, lc3b_word'(i * 2), lc3b_word'($urandom), 0);
        end
        repeat (64) begin
            addr = random_addr();
            exec(op_str, addr, lc3b_word'($urandom), 0);
            exec(op_ldr, addr, '0, 0);
            exec(op_ldr, random_addr(), '0, 0);
        end
        end_test();

        start_test("wait_states");
        repeat (16) begin
            set_timing($urandom_range(15), 1'b0);
            addr = random_addr();
            exec(op_str, addr, lc3b_word'($urandom), 0);
            exec(op_ldr, addr, '0, 0);
        end
        end_test();

        start_test("indirect");
        repeat (16) begin
            set_timing($urandom_range(15), 1'b0);
            addr   = random_addr();
            target = word_of(addr) + sram_addr'($urandom_range(1, 255));
            ptr    = lc3b_word'($urandom);
            ptr[8:1] = target;
            data   = lc3b_word'($urandom);
            exec(op_str, addr, ptr, 0);
            exec(op_sti, addr, data, 0);
            exec(op_ldr, addr, '0, 0);
            exec(op_ldi, addr, '0, 0);
            exec(op_ldi, random_addr(), '0, 0);
        end
        end_test();

        start_test("retry");
        repeat (8) begin
            set_timing($urandom_range(15), 1'b1);
            repeat (6) begin
                exec(mem_ops[$urandom_range(3)], random_addr(), lc3b_word'($urandom), 0);
            end
        end
        end_test();

        start_test("hold");
        repeat (8) begin
            set_timing($urandom_range(15), 1'($urandom_range(1)));
            repeat (8) begin
                exec(mem_ops[$urandom_range(3)], random_addr(), lc3b_word'($urandom), 30);
            end
        end
        end_test();

        start_test("mixed_stream");
        repeat (10) begin
            set_timing($urandom_range(15), 1'($urandom_range(1)));
            repeat (20) begin
                exec(mem_ops[$urandom_range(3)], random_addr(), lc3b_word'($urandom), 10);
            end
        end
        set_timing(0, 1'b0);
        for (int i = 0; i < sram_depth; i++) begin
            exec(op_ldr, lc3b_word'(i * 2), '0, 0);
        end
        end_test();

        $display("Summary: %0d tests, %0d checks, %0d mismatches", tests, checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : tb_lc3b_mem_stage

`default_nettype wire

// File: lc3b_mem_stage.f
hw/lc3b_isa_pkg.sv
hw/lc3b_mem_pkg.sv
hw/mem_access_controller.sv
hw/mem_stage_datapath.sv
hw/data_sram.sv
hw/mem_timing_regs.sv
hw/lc3b_mem_stage.sv
+incdir+verification
verification/tb_lc3b_mem_stage.sv
